/* tb.f */
verilog/sin_gen_pkg.sv
verilog/phase_accumulator.sv
verilog/cordic_sin.sv
verilog/sample_fifo.sv
verilog/pdm_modulator.sv
verilog/sin_gen.sv
testbench/sin_gen_checker.sv
testbench/tb_sin_gen.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the sin_gen testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module tb_sin_gen -f tb.f

# an assertion may end the run with a nonzero status, the log decides
./obj_dir/Vtb_sin_gen +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "^NO ERRORS$" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi

/* testbench/tb_sin_gen.sv */
`timescale 1ns/100ps

module tb_sin_gen;
  import sin_gen_pkg::*;

  localparam int fifo_depth_log2 = 3;
  localparam int depth = 2 ** fifo_depth_log2;
  localparam int sample_tol = 3;
  localparam int fill_limit = 400;  // depth samples at about 24 cycles each
  localparam int empty_limit = 64;  // one rotation plus slack
  localparam int cycle_limit = 20000;  // tests need about 3000 cycles

  logic clk;
  logic rst;
  logic signed [phase_w-1:0] delta_angle;
  logic get_next_sample;
  sample_t sample;
  logic current_sample;
  logic underflow;

  int errors;
  int test_errors;  // errors before the current test
  int tests_run;
  int cycles = 0;
  logic [31:0] lcg_state;

  sin_gen #(
    .fifo_depth_log2(fifo_depth_log2)
  ) i_sin_gen (
    .clk             (clk),
    .rst             (rst),
    .delta_angle     (delta_angle),
    .get_next_sample (get_next_sample),
    .sample          (sample),
    .current_sample  (current_sample),
    .underflow       (underflow)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout, run stopped after %0d cycles", cycles);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // round(32767 * sin(2 pi phase / 2**24))
  function automatic sample_t sine_ref(input logic [phase_w-1:0] phase);
    real r;
    r = 32767.0 * $sin(6.283185307179586 * real'(phase) / 16777216.0);
    if (r >= 0.0) begin
      return sample_t'($rtoi(r + 0.5));
    end
    return sample_t'(-$rtoi(0.5 - r));
  endfunction

  task automatic compare_sample(input string name, input sample_t got, input sample_t exp,
                                input int tol);
    int diff;
    diff = int'(got) - int'(exp);
    if (diff > tol || diff < -tol) begin
      $display("error: %s got 0x%h expected 0x%h within %0d", name, got, exp, tol);
      errors++;
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error: %s got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic compare_count(input string name, input int got, input int lo, input int hi);
    if (got < lo || got > hi) begin
      $display("error: %s got 0x%h expected 0x%h to 0x%h", name, got, lo, hi);
      errors++;
    end
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (errors == test_errors) begin
      $display("test %0d %s passed", tests_run, name);
    end else begin
      $display("test %0d %s failed with %0d errors", tests_run, name, errors - test_errors);
    end
    test_errors = errors;
  endtask

  // phase restarts at 0 with the new step
  task automatic reset_dut(input logic signed [phase_w-1:0] step);
    rst = 1'b1;
    get_next_sample = 1'b0;
    delta_angle = step;
    repeat (16) @(negedge clk);
    rst = 1'b0;
  endtask

  task automatic wait_fifo_full();
    int waited;
    waited = 0;
    while (!i_sin_gen.i_sample_fifo.full && waited < fill_limit) begin
      @(negedge clk);
      waited++;
    end
    if (!i_sin_gen.i_sample_fifo.full) begin
      $display("fifo did not fill within %0d cycles", fill_limit);
      errors++;
    end
  endtask

  task automatic request_sample(output sample_t got);
    int waited;
    waited = 0;
    while (i_sin_gen.fifo_empty && waited < empty_limit) begin
      @(negedge clk);
      waited++;
    end
    if (i_sin_gen.fifo_empty) begin
      $display("no new sample reached the fifo within %0d cycles", empty_limit);
      errors++;
    end
    get_next_sample = 1'b1;
    @(negedge clk);
    get_next_sample = 1'b0;
    got = sample;
  endtask

  task automatic test_reset_state();
    reset_dut('0);
    compare_sample("sample", sample, '0, 0);
    compare_bit("underflow", underflow, 1'b0);
    compare_bit("current_sample", current_sample, 1'b0);
    report_test("reset_state");
  endtask

  task automatic test_zero_step();
    sample_t got;
    logic prev;
    reset_dut('0);
    wait_fifo_full();
    repeat (4) begin
      request_sample(got);
      compare_sample("sample", got, '0, sample_tol);
    end
    @(negedge clk);
    prev = current_sample;
    repeat (32) begin
      @(negedge clk);
      compare_bit("current_sample", current_sample, ~prev);  // u is mid scale
      prev = current_sample;
    end
    report_test("zero_step");
  endtask

  task automatic test_quarter_step();
    sample_t got;
    sample_t expected [4];
    expected = '{16'sd0, 16'sd32767, 16'sd0, -16'sd32767};
    reset_dut(24'sh400000);
    wait_fifo_full();
    for (int n = 0; n < depth; n++) begin
      request_sample(got);
      compare_sample("sample", got, expected[n % 4], sample_tol);
    end
    report_test("quarter_step");
  endtask

  task automatic test_random_steps();
    sample_t got;
    logic [phase_w-1:0] phase;
    logic signed [phase_w-1:0] step;
    for (int k = 0; k < 5; k++) begin
      lcg_state = lcg_next(lcg_state);
      step = lcg_state[31:8];
      reset_dut(step);
      wait_fifo_full();
      phase = '0;
      for (int n = 0; n < 12; n++) begin
        request_sample(got);  // past depth the fifo refills under back-pressure
        compare_sample("sample", got, sine_ref(phase), sample_tol);
        phase = phase + step;
      end
    end
    report_test("random_steps");
  endtask

  task automatic test_underflow();
    sample_t got;
    sample_t held;
    reset_dut(24'sh100000);
    wait_fifo_full();
    repeat (depth) request_sample(got);
    held = got;
    get_next_sample = 1'b1;
    @(negedge clk);
    get_next_sample = 1'b0;
    compare_bit("underflow", underflow, 1'b1);
    compare_sample("sample", sample, held, 0);
    @(negedge clk);
    compare_bit("underflow", underflow, 1'b0);  // single cycle pulse
    report_test("underflow");
  endtask

  task automatic test_pdm_density();
    sample_t got;
    sample_t s_ref;
    int ones;
    int num;
    reset_dut(24'sh200000);
    wait_fifo_full();
    request_sample(got);
    request_sample(got);  // eighth turn
    s_ref = sine_ref(24'h200000);
    compare_sample("sample", got, s_ref, sample_tol);
    @(negedge clk);
    ones = 0;
    repeat (256) begin
      @(negedge clk);
      if (current_sample) begin
        ones++;
      end
    end
    // 256 * (s + 32768) / 65536, plus or minus one
    num = 256 * (int'(s_ref) + 32768);
    compare_count("current_sample ones", ones, (num - 1) / 65536, (num + 65536) / 65536);
    report_test("pdm_density");
  endtask

  initial begin
    rst = 1'b1;
    delta_angle = '0;
    get_next_sample = 1'b0;
    errors = 0;
    test_errors = 0;
    tests_run = 0;
    lcg_state = 32'hb120;
    test_reset_state();
    test_zero_step();
    test_quarter_step();
    test_random_steps();
    test_underflow();
    test_pdm_density();
    errors += i_sin_gen.i_sin_gen_checker.failures;
    $display("%0d tests run, %0d errors including %0d assertion failures", tests_run, errors,
             i_sin_gen.i_sin_gen_checker.failures);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* testbench/sin_gen_checker.sv */
`timescale 1ns/100ps

module sin_gen_checker #(
  parameter int fifo_depth_log2 = 3
) (
  input logic                      clk,
  input logic                      rst,
  input logic                      busy,
  input logic                      out_valid,
  input logic                      angle_valid,
  input logic                      fifo_empty,
  input logic [fifo_depth_log2:0]  fifo_count,
  input logic                      underflow,
  input logic                      current_sample
);
  import sin_gen_pkg::*;

  localparam int depth = 2 ** fifo_depth_log2;

  int failures = 0;  // summed into the testbench count
  logic [5:0] busy_len;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_len <= '0;
    end else if (busy) begin
      busy_len <= busy_len + 6'd1;
    end else begin
      busy_len <= '0;
    end
  end

  rotation_length: assert property (@(posedge clk) disable iff (rst)
    $fell(busy) |-> busy_len == 6'(cordic_steps))
  else begin
    $error("busy did not last %0d cycles", cordic_steps);
    failures++;
  end

  rotation_bound: assert property (@(posedge clk) disable iff (rst)
    busy |-> busy_len < 6'(cordic_steps))
  else begin
    $error("busy held past the last rotation step");
    failures++;
  end

  result_after_rotation: assert property (@(posedge clk) disable iff (rst)
    $fell(busy) |=> out_valid)
  else begin
    $error("out_valid did not follow the end of busy");
    failures++;
  end

  // core only takes an angle in idle
  accept_in_idle: assert property (@(posedge clk) disable iff (rst)
    angle_valid |-> !busy)
  else begin
    $error("angle_valid raised while the core was busy");
    failures++;
  end

  no_write_when_full: assert property (@(posedge clk) disable iff (rst)
    out_valid |-> fifo_count < (fifo_depth_log2 + 1)'(depth))
  else begin
    $error("fifo written while full");
    failures++;
  end

  // empty and no write, so nothing may be popped
  no_read_when_empty: assert property (@(posedge clk) disable iff (rst)
    fifo_empty && !out_valid |=> fifo_empty)
  else begin
    $error("fifo read while empty");
    failures++;
  end

  reset_outputs_low: assert property (@(posedge clk)
    rst |=> !busy && !out_valid && !angle_valid && !underflow && !current_sample)
  else begin
    $error("control outputs not low after reset");
    failures++;
  end

endmodule

// top level holds the core and the fifo side by side
bind sin_gen sin_gen_checker #(
  .fifo_depth_log2(fifo_depth_log2)
) i_sin_gen_checker (
  .clk            (clk),
  .rst            (rst),
  .busy           (busy),
  .out_valid      (core_valid),
  .angle_valid    (angle_valid),
  .fifo_empty     (fifo_empty),
  .fifo_count     (fifo_count),
  .underflow      (underflow),
  .current_sample (current_sample)
);

/* verilog/sin_gen.sv */
`timescale 1ns/100ps

module sin_gen #(
  parameter int fifo_depth_log2 = 3
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic signed [sin_gen_pkg::phase_w-1:0] delta_angle,
  input  logic                                  get_next_sample,
  output sin_gen_pkg::sample_t                  sample,
  output logic                                  current_sample,
  output logic                                  underflow
);
  import sin_gen_pkg::*;

  angle_t angle;
  logic angle_valid;
  logic busy;
  logic core_valid;  // also the fifo write strobe
  sample_t core_sample;
  sample_t fifo_rd_data;
  logic fifo_rd_en;
  logic fifo_empty;
  logic [fifo_depth_log2:0] fifo_count;

  phase_accumulator #(
    .fifo_depth_log2(fifo_depth_log2)
  ) i_phase_accumulator (
    .clk         (clk),
    .rst         (rst),
    .delta_angle (delta_angle),
    .busy        (busy),
    .fifo_count  (fifo_count),
    .out_valid   (core_valid),
    .angle       (angle),
    .angle_valid (angle_valid)
  );

  cordic_sin i_cordic_sin (
    .clk         (clk),
    .rst         (rst),
    .angle       (angle),
    .angle_valid (angle_valid),
    .sample      (core_sample),
    .out_valid   (core_valid),
    .busy        (busy)
  );

  sample_fifo #(
    .fifo_depth_log2(fifo_depth_log2)
  ) i_sample_fifo (
    .clk     (clk),
    .rst     (rst),
    .wr_en   (core_valid),
    .wr_data (core_sample),
    .rd_en   (fifo_rd_en),
    .rd_data (fifo_rd_data),
    .empty   (fifo_empty),
    .full    (),  // accumulator budgets space via fifo_count
    .count   (fifo_count)
  );

  pdm_modulator i_pdm_modulator (
    .clk             (clk),
    .rst             (rst),
    .get_next_sample (get_next_sample),
    .empty           (fifo_empty),
    .rd_data         (fifo_rd_data),
    .rd_en           (fifo_rd_en),
    .sample          (sample),
    .underflow       (underflow),
    .current_sample  (current_sample)
  );

endmodule

/* verilog/pdm_modulator.sv */
`timescale 1ns/100ps

module pdm_modulator (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  get_next_sample,
  input  logic                  empty,
  input  sin_gen_pkg::sample_t  rd_data,
  output logic                  rd_en,
  output sin_gen_pkg::sample_t  sample,
  output logic                  underflow,
  output logic                  current_sample
);
  import sin_gen_pkg::*;

  logic [sample_w-1:0] u;
  logic [sample_w-1:0] acc;
  logic [sample_w:0] sum;

  assign rd_en = get_next_sample && !empty;

  // flip the sign bit, 0 maps to mid scale
  assign u = {~sample[sample_w-1], sample[sample_w-2:0]};
  assign sum = {1'b0, acc} + {1'b0, u};

  always_ff @(posedge clk) begin
    if (rst) begin
      sample <= '0;
      underflow <= 1'b0;
      acc <= '0;
      current_sample <= 1'b0;
    end else begin
      underflow <= get_next_sample && empty;  // sample holds
      if (rd_en) begin
        sample <= rd_data;
      end
      acc <= sum[sample_w-1:0];
      current_sample <= sum[sample_w];  // carry is the density bit
    end
  end

endmodule

/* verilog/sample_fifo.sv */
`timescale 1ns/100ps

module sample_fifo #(
  parameter int fifo_depth_log2 = 3
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      wr_en,
  input  sin_gen_pkg::sample_t      wr_data,
  input  logic                      rd_en,
  output sin_gen_pkg::sample_t      rd_data,
  output logic                      empty,
  output logic                      full,
  output logic [fifo_depth_log2:0]  count
);
  import sin_gen_pkg::*;

  localparam int depth = 2 ** fifo_depth_log2;

  sample_t mem [depth];
  logic [fifo_depth_log2-1:0] wr_ptr;
  logic [fifo_depth_log2-1:0] rd_ptr;
  logic do_wr;
  logic do_rd;

  assign empty = (count == '0);
  assign full = (count == (fifo_depth_log2 + 1)'(depth));
  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;
  assign rd_data = mem[rd_ptr];  // show-ahead, head word always visible

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;  // both or neither
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

endmodule

/* verilog/cordic_sin.sv */
`timescale 1ns/100ps

module cordic_sin (
  input  logic                  clk,
  input  logic                  rst,
  input  sin_gen_pkg::angle_t   angle,
  input  logic                  angle_valid,
  output sin_gen_pkg::sample_t  sample,
  output logic                  out_valid,
  output logic                  busy
);
  import sin_gen_pkg::*;

  localparam int step_w = $clog2(cordic_steps);
  localparam int round_shift = angle_frac_w - (sample_w - 1);

  // atan(2**-i) for the first steps
  localparam angle_t atan_table [0:7] = '{
    24'sh3243F7,
    24'sh1DAC67,
    24'sh0FADBB,
    24'sh07F56F,
    24'sh03FEAB,
    24'sh01FFD5,
    24'sh00FFFB,
    24'sh007FFF
  };

  cordic_state_t state;
  logic [step_w-1:0] step;
  angle_t x;
  angle_t y;
  angle_t z;  // residual angle
  angle_t atan;
  angle_t y_round;
  sample_t sat_sample;
  logic clk_wise;

  assign busy = (state == rotate);
  assign clk_wise = z[angle_w-1];  // overshoot, rotate back

  always_comb begin
    if (step < step_w'(8)) begin
      atan = atan_table[step[2:0]];
    end else begin
      atan = angle_t'(1 << angle_frac_w) >> step;  // atan(a) ~ a
    end
  end

  always_comb begin
    y_round = (y + angle_t'(1 << (round_shift - 1))) >>> round_shift;
    if (y_round > angle_t'(sample_max)) begin
      sat_sample = sample_t'(sample_max);
    end else if (y_round < -angle_t'(sample_max)) begin
      sat_sample = -sample_t'(sample_max);
    end else begin
      sat_sample = sample_t'(y_round);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= idle;
      step <= '0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= 1'b0;
      case (state)
        idle: begin
          if (angle_valid) begin
            state <= rotate;
            step <= '0;
          end
        end
        rotate: begin
          step <= step + 1'b1;
          if (step == step_w'(cordic_steps - 1)) begin
            state <= done;
          end
        end
        done: begin
          out_valid <= 1'b1;
          state <= idle;
        end
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      idle: begin
        if (angle_valid) begin
          x <= cordic_x0;
          y <= '0;
          z <= angle;
        end
      end
      rotate: begin
        x <= clk_wise ? x + (y >>> step) : x - (y >>> step);
        y <= clk_wise ? y - (x >>> step) : y + (x >>> step);
        z <= clk_wise ? z + atan : z - atan;
      end
      done: sample <= sat_sample;
      default: ;
    endcase
  end

endmodule

/* verilog/phase_accumulator.sv */
`timescale 1ns/100ps

module phase_accumulator #(
  parameter int fifo_depth_log2 = 3
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic signed [sin_gen_pkg::phase_w-1:0] delta_angle,
  input  logic                                  busy,
  input  logic [fifo_depth_log2:0]              fifo_count,
  input  logic                                  out_valid,
  output sin_gen_pkg::angle_t                   angle,
  output logic                                  angle_valid
);
  import sin_gen_pkg::*;

  localparam int depth = 2 ** fifo_depth_log2;
  localparam int prod_w = quarter_w + 1 + angle_w;
  localparam int occ_w = fifo_depth_log2 + 2;

  logic [phase_w-1:0] phase;
  logic pending;  // issued, not yet written to fifo
  logic [occ_w-1:0] occupancy;
  logic can_issue;
  quadrant_t quadrant;
  logic [quarter_w-1:0] frac;
  logic [quarter_w:0] fold_frac;
  logic [prod_w-1:0] prod;
  angle_t magnitude;
  angle_t folded_angle;

  assign quadrant = quadrant_t'(phase[phase_w-1 -: 2]);
  assign frac = phase[quarter_w-1:0];

  // fifo plus in flight, so a result always has room
  assign occupancy = {1'b0, fifo_count} + occ_w'(pending);
  assign can_issue = !busy && !pending && (occupancy < occ_w'(depth));

  always_comb begin
    case (quadrant)
      q1, q3:  fold_frac = (quarter_w + 1)'(1 << quarter_w) - {1'b0, frac};  // mirror
      default: fold_frac = {1'b0, frac};
    endcase
    // quarter fraction to radians, rounded
    prod = prod_w'(fold_frac) * prod_w'(two_pi_scale) + prod_w'(1 << (quarter_w - 1));
    magnitude = angle_t'(prod >> quarter_w);
    case (quadrant)
      q2, q3:  folded_angle = -magnitude;  // lower half of the circle
      default: folded_angle = magnitude;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      phase <= '0;
      pending <= 1'b0;
      angle_valid <= 1'b0;
    end else begin
      angle_valid <= can_issue;
      if (can_issue) begin
        phase <= phase + delta_angle;
        pending <= 1'b1;
      end else if (out_valid) begin
        pending <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (can_issue) begin
      angle <= folded_angle;
    end
  end

endmodule

/* verilog/sin_gen_pkg.sv */
package sin_gen_pkg;

  // phase word, one full turn is 2**phase_w
  localparam int phase_w = 24;
  localparam int quarter_w = phase_w - 2;  // fraction bits inside a quadrant

  // cordic angle, two's complement with 2 integer bits
  localparam int angle_w = 24;
  localparam int angle_frac_w = angle_w - 2;

  localparam int sample_w = 16;
  localparam int sample_max = 2 ** (sample_w - 1) - 1;

  localparam int cordic_steps = 20;

  typedef logic signed [sample_w-1:0] sample_t;
  typedef logic signed [angle_w-1:0] angle_t;

  localparam angle_t cordic_x0 = 24'sh26DD12;  // 1/K, gain compensated

  // 2*pi with 20 fraction bits, i.e. pi/2 in angle format
  localparam logic [angle_w-1:0] two_pi_scale = 24'h6487ED;

  typedef enum logic [1:0] {
    idle,
    rotate,
    done
  } cordic_state_t;

  typedef enum logic [1:0] {
    q0,
    q1,
    q2,
    q3
  } quadrant_t;

endpackage
